/* verilog/haar_pkg.sv */
package haar_pkg;

  // Window and cascade sizes.
  localparam int DATA_WIDTH      = 12;
  localparam int WIN_CELLS       = 9;
  localparam int IDX_WIDTH       = 4;
  localparam int NUM_STAGES      = 3;
  localparam int NUM_CLASSIFIERS = 10;
  localparam int STAGE_ENTRIES   = NUM_CLASSIFIERS + 1;
  localparam int MEM_DEPTH       = NUM_STAGES * STAGE_ENTRIES;
  localparam int ADDR_WIDTH      = 6;

  localparam int FEAT_WIDTH = 16;
  localparam int VOTE_WIDTH = 12;
  localparam int SUM_WIDTH  = 16;

  // Entry layout, counted from bit 0.
  localparam int CORNER_A_LSB   = 0;
  localparam int CORNER_B_LSB   = CORNER_A_LSB + IDX_WIDTH;
  localparam int CORNER_C_LSB   = CORNER_B_LSB + IDX_WIDTH;
  localparam int CORNER_D_LSB   = CORNER_C_LSB + IDX_WIDTH;
  localparam int NEGATE_BIT     = CORNER_D_LSB + IDX_WIDTH;
  localparam int FEAT_THR_LSB   = NEGATE_BIT + 1;
  localparam int LEFT_VOTE_LSB  = FEAT_THR_LSB + FEAT_WIDTH;
  localparam int RIGHT_VOTE_LSB = LEFT_VOTE_LSB + VOTE_WIDTH;
  localparam int SPARE_LSB      = RIGHT_VOTE_LSB + VOTE_WIDTH;
  localparam int SPARE_WIDTH    = 16;
  localparam int ENTRY_WIDTH    = SPARE_LSB + SPARE_WIDTH;

  typedef enum logic [1:0] {
    OP_NONE,
    OP_CLEAR,
    OP_FEATURE,
    OP_THRESH
  } entry_op_t;

  typedef enum logic [1:0] {
    S_IDLE,
    S_ISSUE,
    S_WAIT,
    S_DONE
  } ctrl_state_t;

endpackage

/* verilog/classifier_rom.sv */
`timescale 1ns/1ps

module classifier_rom (
  input  logic                                 clk_fpga,
  input  logic                                 rst,
  input  logic                                 mem_wr_en,
  input  logic [haar_pkg::ADDR_WIDTH-1:0]      mem_wr_addr,
  input  logic [haar_pkg::ENTRY_WIDTH-1:0]     mem_wr_data,
  input  haar_pkg::entry_op_t                  rd_op,
  input  logic [haar_pkg::ADDR_WIDTH-1:0]      rd_addr,
  output logic [haar_pkg::ENTRY_WIDTH-1:0]     entry,
  output haar_pkg::entry_op_t                  entry_op
);

  logic [haar_pkg::ENTRY_WIDTH-1:0] mem [haar_pkg::MEM_DEPTH];

  always_ff @(posedge clk_fpga) begin
    if (mem_wr_en) begin
      mem[mem_wr_addr] <= mem_wr_data;
    end
    entry <= mem[rd_addr];
  end

  // Opcode follows the read by one cycle.
  always_ff @(posedge clk_fpga) begin
    if (rst) begin
      entry_op <= haar_pkg::OP_NONE;
    end else begin
      entry_op <= rd_op;
    end
  end

endmodule

/* verilog/feature_eval.sv */
`timescale 1ns/1ps

module feature_eval (
  input  logic                                              clk_fpga,
  input  logic                                              rst,
  input  logic                                              load_window,
  input  logic [haar_pkg::WIN_CELLS-1:0][haar_pkg::DATA_WIDTH-1:0] window,
  input  logic [haar_pkg::ENTRY_WIDTH-1:0]                  entry,
  input  haar_pkg::entry_op_t                               entry_op,
  output logic signed [haar_pkg::VOTE_WIDTH-1:0]            vote,
  output haar_pkg::entry_op_t                               vote_op,
  output logic signed [haar_pkg::SUM_WIDTH-1:0]             stage_threshold
);

  logic [haar_pkg::WIN_CELLS-1:0][haar_pkg::DATA_WIDTH-1:0] win_q;
  logic signed [haar_pkg::FEAT_WIDTH-1:0] ext_a, ext_b, ext_c, ext_d;
  logic signed [haar_pkg::FEAT_WIDTH-1:0] rect_sum;
  logic signed [haar_pkg::FEAT_WIDTH-1:0] feat;
  logic signed [haar_pkg::FEAT_WIDTH-1:0] feat_thr;
  logic signed [haar_pkg::VOTE_WIDTH-1:0] sel_vote;

  // Corner lookup, zero extended. Indices past the window read as zero.
  function automatic logic signed [haar_pkg::FEAT_WIDTH-1:0] cell_at(
    input logic [haar_pkg::WIN_CELLS-1:0][haar_pkg::DATA_WIDTH-1:0] win,
    input logic [haar_pkg::IDX_WIDTH-1:0] idx
  );
    cell_at = '0;
    if (idx < haar_pkg::WIN_CELLS) begin
      cell_at = {{(haar_pkg::FEAT_WIDTH - haar_pkg::DATA_WIDTH){1'b0}}, win[idx]};
    end
  endfunction

  always_ff @(posedge clk_fpga) begin
    if (load_window) begin
      win_q <= window;
    end
  end

  always_comb begin
    ext_a    = cell_at(win_q, entry[haar_pkg::CORNER_A_LSB +: haar_pkg::IDX_WIDTH]);
    ext_b    = cell_at(win_q, entry[haar_pkg::CORNER_B_LSB +: haar_pkg::IDX_WIDTH]);
    ext_c    = cell_at(win_q, entry[haar_pkg::CORNER_C_LSB +: haar_pkg::IDX_WIDTH]);
    ext_d    = cell_at(win_q, entry[haar_pkg::CORNER_D_LSB +: haar_pkg::IDX_WIDTH]);
    rect_sum = ext_d - ext_b - ext_c + ext_a;
    feat     = entry[haar_pkg::NEGATE_BIT] ? -rect_sum : rect_sum;
    feat_thr = entry[haar_pkg::FEAT_THR_LSB +: haar_pkg::FEAT_WIDTH];
    if (feat < feat_thr) begin
      sel_vote = entry[haar_pkg::LEFT_VOTE_LSB +: haar_pkg::VOTE_WIDTH];
    end else begin
      sel_vote = entry[haar_pkg::RIGHT_VOTE_LSB +: haar_pkg::VOTE_WIDTH];
    end
  end

  always_ff @(posedge clk_fpga) begin
    if (entry_op == haar_pkg::OP_FEATURE) begin
      vote <= sel_vote;
    end
    if (entry_op == haar_pkg::OP_THRESH) begin
      stage_threshold <= entry[haar_pkg::SUM_WIDTH-1:0];
    end
  end

  always_ff @(posedge clk_fpga) begin
    if (rst) begin
      vote_op <= haar_pkg::OP_NONE;
    end else begin
      vote_op <= entry_op;
    end
  end

endmodule

/* verilog/stage_accumulator.sv */
`timescale 1ns/1ps

module stage_accumulator (
  input  logic                                   clk_fpga,
  input  logic                                   rst,
  input  logic signed [haar_pkg::VOTE_WIDTH-1:0] vote,
  input  haar_pkg::entry_op_t                    vote_op,
  input  logic signed [haar_pkg::SUM_WIDTH-1:0]  stage_threshold,
  output logic                                   stage_valid,
  output logic                                   stage_pass
);

  logic signed [haar_pkg::SUM_WIDTH-1:0] total;

  // Running total, sign extended vote on each feature.
  always_ff @(posedge clk_fpga) begin
    if (rst) begin
      total <= '0;
    end else begin
      case (vote_op)
        haar_pkg::OP_CLEAR:   total <= '0;
        haar_pkg::OP_FEATURE: total <= total + vote;
        default:              total <= total;
      endcase
    end
  end

  // Verdict once the threshold entry arrives.
  always_ff @(posedge clk_fpga) begin
    if (rst) begin
      stage_valid <= 1'b0;
      stage_pass  <= 1'b0;
    end else begin
      stage_valid <= (vote_op == haar_pkg::OP_THRESH);
      if (vote_op == haar_pkg::OP_THRESH) begin
        stage_pass <= (total >= stage_threshold);
      end
    end
  end

endmodule

/* verilog/cascade_control.sv */
`timescale 1ns/1ps

module cascade_control (
  input  logic                            clk_fpga,
  input  logic                            rst,
  input  logic                            start,
  input  logic                            stage_valid,
  input  logic                            stage_pass,
  output logic                            load_window,
  output haar_pkg::entry_op_t             rd_op,
  output logic [haar_pkg::ADDR_WIDTH-1:0] rd_addr,
  output logic                            busy,
  output logic                            done,
  output logic                            candidate
);

  haar_pkg::ctrl_state_t state;

  logic [$clog2(haar_pkg::NUM_STAGES)-1:0] stage_cnt;
  logic [haar_pkg::ADDR_WIDTH-1:0]         ent_cnt;
  logic [haar_pkg::ADDR_WIDTH-1:0]         stage_base;
  logic [haar_pkg::ADDR_WIDTH-1:0]         rd_offset;

  assign load_window = (state == haar_pkg::S_IDLE) && start;
  assign busy        = (state != haar_pkg::S_IDLE);
  assign done        = (state == haar_pkg::S_DONE);

  assign stage_base = haar_pkg::ADDR_WIDTH'(stage_cnt * haar_pkg::STAGE_ENTRIES);
  assign rd_addr    = stage_base + rd_offset;

  // Entry 0 clears, 1..10 are features, 11 is the threshold.
  always_comb begin
    rd_op     = haar_pkg::OP_NONE;
    rd_offset = '0;
    if (state == haar_pkg::S_ISSUE) begin
      if (ent_cnt == '0) begin
        rd_op = haar_pkg::OP_CLEAR;
      end else if (ent_cnt <= haar_pkg::NUM_CLASSIFIERS) begin
        rd_op     = haar_pkg::OP_FEATURE;
        rd_offset = ent_cnt - 1'b1;
      end else begin
        rd_op     = haar_pkg::OP_THRESH;
        rd_offset = haar_pkg::ADDR_WIDTH'(haar_pkg::NUM_CLASSIFIERS);
      end
    end
  end

  always_ff @(posedge clk_fpga) begin
    if (rst) begin
      state     <= haar_pkg::S_IDLE;
      stage_cnt <= '0;
      ent_cnt   <= '0;
      candidate <= 1'b0;
    end else begin
      case (state)
        haar_pkg::S_IDLE: begin
          if (start) begin
            state     <= haar_pkg::S_ISSUE;
            stage_cnt <= '0;
            ent_cnt   <= '0;
          end
        end
        haar_pkg::S_ISSUE: begin
          if (ent_cnt == haar_pkg::ADDR_WIDTH'(haar_pkg::STAGE_ENTRIES)) begin
            state <= haar_pkg::S_WAIT;
          end else begin
            ent_cnt <= ent_cnt + 1'b1;
          end
        end
        haar_pkg::S_WAIT: begin
          if (stage_valid) begin
            // Stop on the first rejection or after the last stage.
            if (!stage_pass || stage_cnt == haar_pkg::NUM_STAGES - 1) begin
              state     <= haar_pkg::S_DONE;
              candidate <= stage_pass;
            end else begin
              state     <= haar_pkg::S_ISSUE;
              stage_cnt <= stage_cnt + 1'b1;
              ent_cnt   <= '0;
            end
          end
        end
        default: begin
          state <= haar_pkg::S_IDLE;
        end
      endcase
    end
  end

endmodule

/* verilog/haar_first_phase.sv */
`timescale 1ns/1ps

module haar_first_phase (
  input  logic                                              clk_fpga,
  input  logic                                              rst,
  input  logic                                              start,
  input  logic [haar_pkg::WIN_CELLS-1:0][haar_pkg::DATA_WIDTH-1:0] window,
  input  logic                                              mem_wr_en,
  input  logic [haar_pkg::ADDR_WIDTH-1:0]                   mem_wr_addr,
  input  logic [haar_pkg::ENTRY_WIDTH-1:0]                  mem_wr_data,
  output logic                                              busy,
  output logic                                              done,
  output logic                                              candidate
);

  logic                                   load_window;
  haar_pkg::entry_op_t                    rd_op;
  logic [haar_pkg::ADDR_WIDTH-1:0]        rd_addr;
  logic [haar_pkg::ENTRY_WIDTH-1:0]       entry;
  haar_pkg::entry_op_t                    entry_op;
  logic signed [haar_pkg::VOTE_WIDTH-1:0] vote;
  haar_pkg::entry_op_t                    vote_op;
  logic signed [haar_pkg::SUM_WIDTH-1:0]  stage_threshold;
  logic                                   stage_valid;
  logic                                   stage_pass;

  cascade_control u_control (
    .clk_fpga    (clk_fpga),
    .rst         (rst),
    .start       (start),
    .stage_valid (stage_valid),
    .stage_pass  (stage_pass),
    .load_window (load_window),
    .rd_op       (rd_op),
    .rd_addr     (rd_addr),
    .busy        (busy),
    .done        (done),
    .candidate   (candidate)
  );

  classifier_rom u_rom (
    .clk_fpga    (clk_fpga),
    .rst         (rst),
    .mem_wr_en   (mem_wr_en),
    .mem_wr_addr (mem_wr_addr),
    .mem_wr_data (mem_wr_data),
    .rd_op       (rd_op),
    .rd_addr     (rd_addr),
    .entry       (entry),
    .entry_op    (entry_op)
  );

  feature_eval u_feature (
    .clk_fpga        (clk_fpga),
    .rst             (rst),
    .load_window     (load_window),
    .window          (window),
    .entry           (entry),
    .entry_op        (entry_op),
    .vote            (vote),
    .vote_op         (vote_op),
    .stage_threshold (stage_threshold)
  );

  stage_accumulator u_accum (
    .clk_fpga        (clk_fpga),
    .rst             (rst),
    .vote            (vote),
    .vote_op         (vote_op),
    .stage_threshold (stage_threshold),
    .stage_valid     (stage_valid),
    .stage_pass      (stage_pass)
  );

endmodule

/* verification/haar_first_phase_assert.sv */
`timescale 1ns/1ps

module haar_first_phase_assert (
  input logic                clk_fpga,
  input logic                rst,
  input logic                busy,
  input logic                done,
  input logic                candidate,
  input logic                load_window,
  input logic                stage_valid,
  input haar_pkg::entry_op_t rd_op
);

  int fail_count = 0;

  // Done is a single pulse and the FSM is idle right after it.
  done_pulse: assert property (@(posedge clk_fpga) disable iff (rst) done |=> (!done && !busy))
    else begin
      $error("done lasted more than one cycle or busy stayed high after it");
      fail_count++;
    end

  busy_ends_on_done: assert property (@(posedge clk_fpga) disable iff (rst)
    $fell(busy) |-> $past(done))
    else begin
      $error("busy fell without a done pulse");
      fail_count++;
    end

  candidate_on_done: assert property (@(posedge clk_fpga) disable iff (rst)
    $changed(candidate) |-> done)
    else begin
      $error("candidate changed outside a done pulse");
      fail_count++;
    end

  // Everything quiet one cycle into reset.
  reset_quiet: assert property (@(posedge clk_fpga)
    rst |=> (!busy && !done && !candidate && !load_window && !stage_valid &&
             rd_op == haar_pkg::OP_NONE))
    else begin
      $error("control outputs active during reset");
      fail_count++;
    end

endmodule

bind haar_first_phase haar_first_phase_assert u_assert (
  .clk_fpga    (clk_fpga),
  .rst         (rst),
  .busy        (busy),
  .done        (done),
  .candidate   (candidate),
  .load_window (load_window),
  .stage_valid (stage_valid),
  .rd_op       (rd_op)
);

/* verification/haar_first_phase_tb.sv */
`timescale 1ns/1ps

module haar_first_phase_tb;

  localparam int TIMEOUT_CYCLES = 24000;
  localparam int EW = haar_pkg::ENTRY_WIDTH;
  localparam int SE = haar_pkg::STAGE_ENTRIES;

  typedef logic [haar_pkg::WIN_CELLS-1:0][haar_pkg::DATA_WIDTH-1:0] win_t;

  logic                            clk_fpga;
  logic                            rst;
  logic                            start;
  win_t                            window;
  logic                            mem_wr_en;
  logic [haar_pkg::ADDR_WIDTH-1:0] mem_wr_addr;
  logic [EW-1:0]                   mem_wr_data;
  logic                            busy;
  logic                            done;
  logic                            candidate;

  logic [15:0]   lfsr = 16'd57;
  logic [EW-1:0] mem_img [haar_pkg::MEM_DEPTH];
  int            cycle_count = 0;
  int            all_pass_cycles;
  int            cycles;
  logic          result;
  win_t          win;

  haar_first_phase u_haar_first_phase (
    .clk_fpga    (clk_fpga),
    .rst         (rst),
    .start       (start),
    .window      (window),
    .mem_wr_en   (mem_wr_en),
    .mem_wr_addr (mem_wr_addr),
    .mem_wr_data (mem_wr_data),
    .busy        (busy),
    .done        (done),
    .candidate   (candidate)
  );

  initial begin
    clk_fpga = 1'b0;
    forever #20 clk_fpga = ~clk_fpga;
  end

  // Limit covers about 245 evaluations of up to 50 cycles plus loads.
  always @(posedge clk_fpga) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  end

  task automatic step();
    @(posedge clk_fpga);
    #2;
  endtask

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("error %s: expected %0d, actual %0d", test_name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  // Taps 16, 14, 13, 11.
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    int i;
    rand_bits = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      rand_bits = {rand_bits[30:0], lfsr[0]};
    end
  endfunction

  function automatic win_t random_window();
    int i;
    for (i = 0; i < haar_pkg::WIN_CELLS; i++) begin
      random_window[i] = haar_pkg::DATA_WIDTH'(rand_bits(haar_pkg::DATA_WIDTH));
    end
  endfunction

  // Fields from bit 0 are a, b, c, d, negate, threshold, left, right and spare.
  function automatic logic [EW-1:0] random_feature();
    logic [3:0]  a, b, c, d;
    logic        neg;
    logic [13:0] thr;
    logic [11:0] left, right;
    logic [15:0] spare;
    a     = 4'(rand_bits(4) % 9);
    b     = 4'(rand_bits(4) % 9);
    c     = 4'(rand_bits(4) % 9);
    d     = 4'(rand_bits(4) % 9);
    neg   = rand_bits(1) != 0;
    thr   = 14'(rand_bits(14));
    left  = 12'(rand_bits(12));
    right = 12'(rand_bits(12));
    spare = 16'(rand_bits(16));
    random_feature = {spare, right, left, {{2{thr[13]}}, thr}, neg, d, c, b, a};
  endfunction

  function automatic logic [EW-1:0] threshold_entry(input logic [15:0] thr);
    threshold_entry = {{(EW - 16){1'b0}}, thr};
  endfunction

  task automatic write_entry(input int addr, input logic [EW-1:0] data);
    mem_wr_en   = 1'b1;
    mem_wr_addr = haar_pkg::ADDR_WIDTH'(addr);
    mem_wr_data = data;
    mem_img[addr] = data;
    step();
    mem_wr_en = 1'b0;
  endtask

  task automatic load_random_image();
    int s, k;
    logic [11:0] t;
    for (s = 0; s < haar_pkg::NUM_STAGES; s++) begin
      for (k = 0; k < haar_pkg::NUM_CLASSIFIERS; k++) begin
        write_entry(s * SE + k, random_feature());
      end
      t = 12'(rand_bits(12));
      write_entry(s * SE + SE - 1, threshold_entry({{4{t[11]}}, t}));
    end
  endtask

  // Rectangle sum d - b - c + a over zero-extended cells.
  function automatic int feature_vote(input logic [EW-1:0] e, input win_t w);
    int sum;
    sum = int'(w[e[15:12]]) - int'(w[e[7:4]]) - int'(w[e[11:8]]) + int'(w[e[3:0]]);
    if (e[16]) begin
      sum = -sum;
    end
    if (sum < int'($signed(e[32:17]))) begin
      feature_vote = int'($signed(e[44:33]));
    end else begin
      feature_vote = int'($signed(e[56:45]));
    end
  endfunction

  function automatic logic model_candidate(input win_t w);
    int s, k, total;
    model_candidate = 1'b1;
    for (s = 0; s < haar_pkg::NUM_STAGES && model_candidate; s++) begin
      total = 0;
      for (k = 0; k < haar_pkg::NUM_CLASSIFIERS; k++) begin
        total += feature_vote(mem_img[s * SE + k], w);
      end
      // First rejected stage ends the cascade.
      if (total < int'($signed(mem_img[s * SE + SE - 1][15:0]))) begin
        model_candidate = 1'b0;
      end
    end
  endfunction

  task automatic run_window(input string test_name, input win_t w, input int restart_at,
                            output int n_cycles, output logic cand);
    logic expected;
    expected = model_candidate(w);
    window = w;
    start  = 1'b1;
    step();
    start  = 1'b0;
    // Scramble the input so only the latched copy is valid.
    window = ~w;
    n_cycles = 1;
    check_value(test_name, 1, busy);
    while (done !== 1'b1) begin
      start = (n_cycles == restart_at);
      step();
      n_cycles++;
    end
    start = 1'b0;
    check_value(test_name, expected, candidate);
    step();
    check_value(test_name, 0, done);
    check_value(test_name, 0, busy);
    check_value(test_name, expected, candidate);
    cand = candidate;
  endtask

  initial begin
    int i;
    logic [15:0] thr;
    rst         = 1'b1;
    start       = 1'b0;
    window      = '0;
    mem_wr_en   = 1'b0;
    mem_wr_addr = '0;
    mem_wr_data = '0;
    repeat (10) step();
    rst = 1'b0;

    check_value("reset_state", 0, busy);
    check_value("reset_state", 0, done);
    check_value("reset_state", 0, candidate);

    load_random_image();
    for (i = 0; i < 200; i++) begin
      run_window("random_cascade", random_window(), -1, cycles, result);
    end

    for (i = 0; i < haar_pkg::NUM_STAGES; i++) begin
      write_entry(i * SE + SE - 1, threshold_entry(16'h8000));
    end
    for (i = 0; i < 10; i++) begin
      run_window("all_pass", random_window(), -1, all_pass_cycles, result);
      check_value("all_pass", 1, result);
    end

    // Ten votes never reach the largest threshold.
    write_entry(SE - 1, threshold_entry(16'h7fff));
    for (i = 0; i < 10; i++) begin
      run_window("early_reject", random_window(), -1, cycles, result);
      check_value("early_reject", 0, result);
      assert (cycles < all_pass_cycles) else begin
        $display("early_reject: evaluation took %0d cycles, not fewer than all_pass (%0d)",
                 cycles, all_pass_cycles);
        $display("TESTBENCH FAILED");
        $fatal(1);
      end
    end

    // Second start lands inside the first stage.
    load_random_image();
    for (i = 0; i < 10; i++) begin
      run_window("start_ignored", random_window(), 2 + i, cycles, result);
      repeat (20) begin
        step();
        check_value("start_ignored", 0, done);
        check_value("start_ignored", 0, busy);
      end
    end

    load_random_image();
    win = random_window();
    run_window("reload", win, -1, cycles, result);
    for (i = 0; i < 12; i++) begin
      case (i % 4)
        0:       thr = 16'h8000;
        1:       thr = 16'h7fff;
        default: thr = 16'(rand_bits(16)) >>> 3;
      endcase
      write_entry((i % haar_pkg::NUM_STAGES) * SE + SE - 1, threshold_entry(thr));
      run_window("reload", win, -1, cycles, result);
    end

    if (u_haar_first_phase.u_assert.fail_count == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  end

endmodule

/* build.f */
verilog/haar_pkg.sv
verilog/classifier_rom.sv
verilog/feature_eval.sv
verilog/stage_accumulator.sv
verilog/cascade_control.sv
verilog/haar_first_phase.sv
verification/haar_first_phase_assert.sv
verification/haar_first_phase_tb.sv
